/* Bender.yml */
package:
  name: robotNavigator

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/navPkg.sv
      - rtl/drivePkg.sv
      - rtl/navInterfaces.sv
      - rtl/persistenceFilter.sv
      - rtl/toneDetector.sv
      - rtl/junctionDetector.sv
      - rtl/motionArbiter.sv
      - rtl/robotNavigator.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/clockGen.sv
      - verification/robotNavigatorTb.sv

/* robotNavigator.f */
+incdir+rtl
rtl/navPkg.sv
rtl/drivePkg.sv
rtl/navInterfaces.sv
rtl/persistenceFilter.sv
rtl/toneDetector.sv
rtl/junctionDetector.sv
rtl/motionArbiter.sv
rtl/robotNavigator.sv
verification/clockGen.sv
verification/robotNavigatorTb.sv

/* rtl/drivePkg.sv */
package drivePkg;

    ////////////////////
    // line sensor pattern

    // bit 4 is the leftmost sensor
    typedef logic [4:0] linePattern_t;

    localparam linePattern_t LINE_ALL_ONES  = 5'b11111;
    localparam linePattern_t LINE_ALL_ZEROS = 5'b00000;

    // steering class from the qualified pattern
    typedef enum logic [1:0] {
        STEER_CENTER = 2'd0,
        STEER_LEFT   = 2'd1,
        STEER_RIGHT  = 2'd2,
        STEER_NONE   = 2'd3
    } steer_t;

    ////////////////////
    // speed levels

    typedef logic [1:0] speed_t;

    localparam speed_t SPEED_HALT   = 2'd0;
    localparam speed_t SPEED_SLOW   = 2'd1;
    localparam speed_t SPEED_CRUISE = 2'd2;
    localparam speed_t SPEED_FULL   = 2'd3;

endpackage

/* rtl/junctionDetector.sv */
`timescale 1ns/1ps
`include "navConfig.svh"

module junctionDetector (
    input  logic                   clk,
    input  logic                   rst,
    input  drivePkg::linePattern_t lineSensors,
    lineIf.producer                line
);

    drivePkg::linePattern_t pattern;
    drivePkg::steer_t       nextSteer;
    drivePkg::steer_t       steer;
    logic                   patternChanged;
    logic                   leftSeen;
    logic                   rightSeen;
    logic                   junction;
    logic                   onJunction;
    logic                   lost;

    persistenceFilter #(
        .T    (drivePkg::linePattern_t),
        .HOLD (`NAV_LINE_HOLD)
    ) lineFilter_i (
        .clk     (clk),
        .rst     (rst),
        .sample  (lineSensors),
        .stable  (pattern),
        .changed (patternChanged)
    );

    ////////////////////
    // pattern classes

    assign leftSeen  = |pattern[4:3];
    assign rightSeen = |pattern[1:0];

    always_comb begin
        if (pattern == drivePkg::LINE_ALL_ZEROS) nextSteer = drivePkg::STEER_NONE;
        else if (leftSeen && !rightSeen) nextSteer = drivePkg::STEER_LEFT;
        else if (rightSeen && !leftSeen) nextSteer = drivePkg::STEER_RIGHT;
        else nextSteer = drivePkg::STEER_CENTER;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            steer      <= drivePkg::STEER_NONE;
            junction   <= 1'b0;
            onJunction <= 1'b0;
            lost       <= 1'b1;
        end else begin
            steer      <= nextSteer;
            // pulse only on entry to the crossing
            junction   <= patternChanged && (pattern == drivePkg::LINE_ALL_ONES);
            onJunction <= (pattern == drivePkg::LINE_ALL_ONES);
            lost       <= (pattern == drivePkg::LINE_ALL_ZEROS);
        end
    end

    assign line.steer      = steer;
    assign line.junction   = junction;
    assign line.onJunction = onJunction;
    assign line.lost       = lost;

endmodule

/* rtl/motionArbiter.sv */
`timescale 1ns/1ps
`include "navConfig.svh"

module motionArbiter (
    input  logic             clk,
    input  logic             rst,
    toneIf.consumer          tone,
    lineIf.consumer          line,
    output navPkg::navDir_t  driveDir,
    output drivePkg::speed_t driveSpeed
);

    localparam int TURN_CYCLES = `NAV_TURN_CYCLES;
    localparam int TURN_W      = $clog2(TURN_CYCLES + 1);

    typedef enum logic [1:0] {
        FOLLOW,
        WAIT,
        TURN
    } state_t;

    state_t             state;
    state_t             nextState;
    navPkg::navDir_t    followDir;
    navPkg::navDir_t    nextDir;
    navPkg::navDir_t    turnDir;
    drivePkg::speed_t   followSpeed;
    drivePkg::speed_t   nextSpeed;
    logic               loadTurn;
    logic [TURN_W-1:0]  turnCount;

    ////////////////////
    // plain line following

    always_comb begin
        if (line.lost) begin
            followDir   = navPkg::STOP;
            followSpeed = drivePkg::SPEED_HALT;
        end else begin
            case (line.steer)
                drivePkg::STEER_LEFT: begin
                    followDir   = navPkg::LEFT;
                    followSpeed = drivePkg::SPEED_SLOW;
                end
                drivePkg::STEER_RIGHT: begin
                    followDir   = navPkg::RIGHT;
                    followSpeed = drivePkg::SPEED_SLOW;
                end
                default: begin
                    // ease off while a tone is still being qualified
                    followDir   = navPkg::STRAIGHT;
                    followSpeed = tone.qualifying ? drivePkg::SPEED_CRUISE : drivePkg::SPEED_FULL;
                end
            endcase
        end
    end

    ////////////////////
    // junction handling

    always_comb begin
        nextState = state;
        nextDir   = followDir;
        nextSpeed = followSpeed;
        loadTurn  = 1'b0;
        case (state)
            FOLLOW: begin
                if (line.junction && tone.dirValid) begin
                    nextState = TURN;
                    nextDir   = tone.dir;
                    nextSpeed = drivePkg::SPEED_SLOW;
                    loadTurn  = 1'b1;
                end else if (line.junction) begin
                    nextState = WAIT;
                    nextDir   = navPkg::STOP;
                    nextSpeed = drivePkg::SPEED_HALT;
                end
            end
            WAIT: begin
                nextDir   = navPkg::STOP;
                nextSpeed = drivePkg::SPEED_HALT;
                if (tone.dirNew) begin
                    nextState = TURN;
                    nextDir   = tone.dir;
                    nextSpeed = drivePkg::SPEED_SLOW;
                    loadTurn  = 1'b1;
                end else if (!line.onJunction) begin
                    // crossing vanished under us so back to tracking
                    nextState = FOLLOW;
                end
            end
            TURN: begin
                if (turnCount == TURN_W'(TURN_CYCLES - 1)) begin
                    nextState = FOLLOW;
                end else begin
                    nextDir   = turnDir;
                    nextSpeed = drivePkg::SPEED_SLOW;
                end
            end
            default: nextState = FOLLOW;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= FOLLOW;
            driveDir   <= navPkg::STOP;
            driveSpeed <= drivePkg::SPEED_HALT;
            turnCount  <= '0;
        end else begin
            state      <= nextState;
            driveDir   <= nextDir;
            driveSpeed <= nextSpeed;
            if (loadTurn) turnCount <= '0;
            else if (state == TURN) turnCount <= turnCount + 1'b1;
        end
    end

    // keep the turn even if the tone window closes mid-turn
    always_ff @(posedge clk) begin
        if (loadTurn) turnDir <= tone.dir;
    end

endmodule

/* rtl/navConfig.svh */
`ifndef NAV_CONFIG_SVH
`define NAV_CONFIG_SVH

// cycles a tone band must stay put before it counts
`define NAV_TONE_HOLD 8

// cycles a line pattern must stay put before it counts
`define NAV_LINE_HOLD 3

// how long a latched direction stays usable
`define NAV_DIR_HOLD 200

// length of a turn at a junction
`define NAV_TURN_CYCLES 20

`endif

/* rtl/navInterfaces.sv */
`timescale 1ns/1ps

// direction info from the tone detector
interface toneIf;
    logic            dirValid;
    navPkg::navDir_t dir;
    logic            qualifying;
    logic            dirNew;

    modport producer (
        output dirValid,
        output dir,
        output qualifying,
        output dirNew
    );

    modport consumer (
        input dirValid,
        input dir,
        input qualifying,
        input dirNew
    );
endinterface

// track info from the junction detector
interface lineIf;
    drivePkg::steer_t steer;
    logic             junction;
    logic             onJunction;
    logic             lost;

    modport producer (output steer, output junction, output onJunction, output lost);

    modport consumer (input steer, input junction, input onJunction, input lost);
endinterface

/* rtl/navPkg.sv */
package navPkg;

    ////////////////////
    // tone side

    // qualified band, one per filter flag
    typedef enum logic [1:0] {
        BAND_A = 2'd0,
        BAND_B = 2'd1,
        BAND_C = 2'd2,
        BAND_D = 2'd3
    } toneBand_t;

    // band sample as seen by the persistence filter
    typedef struct packed {
        logic      present;
        toneBand_t band;
    } toneSample_t;

    ////////////////////
    // navigation directions where a set msb means halt

    typedef enum logic [2:0] {
        STRAIGHT = 3'b000,
        LEFT     = 3'b001,
        RIGHT    = 3'b010,
        BACK     = 3'b011,
        STOP     = 3'b100
    } navDir_t;

endpackage

/* rtl/persistenceFilter.sv */
`timescale 1ns/1ps

module persistenceFilter #(
    parameter type T    = logic,
    parameter int  HOLD = 4
) (
    input  logic clk,
    input  logic rst,
    input  T     sample,
    output T     stable,
    output logic changed
);

    localparam int COUNT_W = $clog2(HOLD + 1);

    T                   prevSample;
    logic [COUNT_W-1:0] holdCount;

    always_ff @(posedge clk) begin
        if (rst) begin
            prevSample <= T'('0);
            stable     <= T'('0);
            holdCount  <= '0;
            changed    <= 1'b0;
        end else begin
            changed    <= 1'b0;
            prevSample <= sample;
            if (sample != prevSample) begin
                // any movement restarts the run
                holdCount <= '0;
            end else if (holdCount != COUNT_W'(HOLD)) begin
                holdCount <= holdCount + 1'b1;
            end else begin
                // held long enough to pass on
                stable  <= sample;
                changed <= (sample != stable);
            end
        end
    end

endmodule

/* rtl/robotNavigator.sv */
`timescale 1ns/1ps

module robotNavigator (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] toneFlags,
    input  logic [4:0] lineSensors,
    output logic [2:0] driveDir,
    output logic [1:0] driveSpeed
);

    toneIf toneBus ();
    lineIf lineBus ();

    // audio side
    toneDetector toneDetector_i (
        .clk       (clk),
        .rst       (rst),
        .toneFlags (toneFlags),
        .tone      (toneBus.producer)
    );

    // track side
    junctionDetector junctionDetector_i (
        .clk         (clk),
        .rst         (rst),
        .lineSensors (lineSensors),
        .line        (lineBus.producer)
    );

    motionArbiter motionArbiter_i (
        .clk        (clk),
        .rst        (rst),
        .tone       (toneBus.consumer),
        .line       (lineBus.consumer),
        .driveDir   (driveDir),
        .driveSpeed (driveSpeed)
    );

endmodule

/* rtl/toneDetector.sv */
`timescale 1ns/1ps
`include "navConfig.svh"

module toneDetector (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] toneFlags,
    toneIf.producer    tone
);

    localparam int DIR_HOLD = `NAV_DIR_HOLD;
    localparam int HOLD_W   = $clog2(DIR_HOLD);

    navPkg::toneSample_t rawSample;
    navPkg::toneSample_t filtered;
    navPkg::navDir_t     mappedDir;
    navPkg::navDir_t     dir;
    logic                bandChanged;
    logic                latchDir;
    logic                dirValid;
    logic                dirNew;
    logic [HOLD_W-1:0]   holdCount;

    // lowest flag wins
    always_comb begin
        rawSample.present = |toneFlags;
        if (toneFlags[0]) rawSample.band = navPkg::BAND_A;
        else if (toneFlags[1]) rawSample.band = navPkg::BAND_B;
        else if (toneFlags[2]) rawSample.band = navPkg::BAND_C;
        else if (toneFlags[3]) rawSample.band = navPkg::BAND_D;
        else rawSample.band = navPkg::BAND_A;
    end

    persistenceFilter #(
        .T    (navPkg::toneSample_t),
        .HOLD (`NAV_TONE_HOLD)
    ) bandFilter_i (
        .clk     (clk),
        .rst     (rst),
        .sample  (rawSample),
        .stable  (filtered),
        .changed (bandChanged)
    );

    always_comb begin
        case (filtered.band)
            navPkg::BAND_A: mappedDir = navPkg::STRAIGHT;
            navPkg::BAND_B: mappedDir = navPkg::LEFT;
            navPkg::BAND_C: mappedDir = navPkg::RIGHT;
            default:        mappedDir = navPkg::BACK;
        endcase
    end

    // new tones only count once the previous window is over
    assign latchDir = bandChanged && filtered.present && !dirValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            dirValid  <= 1'b0;
            dirNew    <= 1'b0;
            dir       <= navPkg::STOP;
            holdCount <= '0;
        end else begin
            dirNew <= latchDir;
            if (latchDir) begin
                dirValid  <= 1'b1;
                dir       <= mappedDir;
                holdCount <= '0;
            end else if (dirValid) begin
                if (holdCount == HOLD_W'(DIR_HOLD - 1)) begin
                    dirValid <= 1'b0;
                    dir      <= navPkg::STOP;
                end else begin
                    holdCount <= holdCount + 1'b1;
                end
            end
        end
    end

    assign tone.dirValid   = dirValid;
    assign tone.dir        = dir;
    assign tone.dirNew     = dirNew;
    // band heard but filter not caught up yet
    assign tone.qualifying = rawSample.present && (rawSample != filtered);

endmodule

/* verification/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
    parameter real PERIOD       = 4.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // release just after an edge so the DUT sees a clean synchronous reset
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* verification/robotNavigatorTb.sv */
`timescale 1ns/1ps
`include "navConfig.svh"

module robotNavigatorTb;

    localparam int LINE_WAIT = `NAV_LINE_HOLD + 8;
    localparam int TONE_WAIT = `NAV_TONE_HOLD + 6;
    // all test phases added up plus a generous margin
    localparam int TEST_CYCLES = 2 * `NAV_DIR_HOLD + 2 * `NAV_TURN_CYCLES
                               + 20 * LINE_WAIT + 6 * TONE_WAIT;
    localparam int RUN_LIMIT   = TEST_CYCLES + 2000;

    localparam logic [4:0] PAT_CENTER = 5'b00100;
    localparam logic [4:0] PAT_LEFT   = 5'b11000;
    localparam logic [4:0] PAT_RIGHT  = 5'b00011;
    localparam logic [4:0] PAT_ONES   = 5'b11111;
    localparam logic [4:0] PAT_ZEROS  = 5'b00000;

    typedef enum {PH_FOLLOW, PH_WAIT, PH_TURN} phase_t;

    typedef struct packed {
        navPkg::navDir_t  dir;
        drivePkg::speed_t speed;
    } drive_t;

    logic               clk;
    logic               rst;
    logic [3:0]         toneFlags;
    logic [4:0]         lineSensors;
    logic [2:0]         driveDir;
    logic [1:0]         driveSpeed;
    integer             seed = 32'h788fad44;
    int                 dirErrors = 0;
    int                 speedErrors = 0;
    int                 checkCount = 0;
    int                 cycleCount = 0;
    int                 glitchLen;
    navPkg::toneBand_t  band;
    string              expName;
    drive_t             expDrive;
    event               checkNow;

    clockGen #(.PERIOD(4.0), .RESET_CYCLES(3)) clockGen_i (.clk(clk), .rst(rst));

    robotNavigator robotNavigator_i (
        .clk         (clk),
        .rst         (rst),
        .toneFlags   (toneFlags),
        .lineSensors (lineSensors),
        .driveDir    (driveDir),
        .driveSpeed  (driveSpeed)
    );

    ////////////////////
    // reference model

    function automatic navPkg::navDir_t bandDir(input navPkg::toneBand_t b);
        case (b)
            navPkg::BAND_A: return navPkg::STRAIGHT;
            navPkg::BAND_B: return navPkg::LEFT;
            navPkg::BAND_C: return navPkg::RIGHT;
            default:        return navPkg::BACK;
        endcase
    endfunction

    function automatic drive_t expectedDrive(input phase_t phase,
                                             input drivePkg::steer_t steerCls,
                                             input logic qualifying,
                                             input navPkg::navDir_t turnDir);
        drive_t d;
        d = '{dir: navPkg::STOP, speed: 2'd0};
        if (phase == PH_TURN) begin
            d = '{dir: turnDir, speed: 2'd1};
        end else if (phase == PH_FOLLOW) begin
            case (steerCls)
                drivePkg::STEER_LEFT:   d = '{dir: navPkg::LEFT, speed: 2'd1};
                drivePkg::STEER_RIGHT:  d = '{dir: navPkg::RIGHT, speed: 2'd1};
                drivePkg::STEER_CENTER: begin
                    d = '{dir: navPkg::STRAIGHT, speed: qualifying ? 2'd2 : 2'd3};
                end
                default:                d = '{dir: navPkg::STOP, speed: 2'd0};
            endcase
        end
        return d;
    endfunction

    ////////////////////
    // stimulus helpers

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic driveLine(input logic [4:0] pattern);
        @(posedge clk);
        #1;
        lineSensors = pattern;
    endtask

    task automatic driveTone(input logic [3:0] flags);
        @(posedge clk);
        #1;
        toneFlags = flags;
    endtask

    task automatic pickBand(output navPkg::toneBand_t picked);
        logic [31:0] bits;
        bits   = $random(seed);
        picked = navPkg::toneBand_t'(bits[1:0]);
    endtask

    // shorter than the tone hold even with the extra cycle of driveTone
    task automatic pickGlitch(output int len);
        logic [31:0] bits;
        bits = $random(seed);
        len  = 1 + int'(bits % (`NAV_TONE_HOLD - 2));
    endtask

    task automatic requestCheck(input string name, input drive_t expected);
        expName  = name;
        expDrive = expected;
        -> checkNow;
        @(negedge clk);
    endtask

    ////////////////////
    // compare side

    task automatic checkDir(input string name, input navPkg::navDir_t expected,
                            input navPkg::navDir_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: driveDir expected %b, actual %b", name, expected, actual);
            dirErrors++;
        end
    endtask

    task automatic checkSpeed(input string name, input drivePkg::speed_t expected,
                              input drivePkg::speed_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: driveSpeed expected %0d, actual %0d", name, expected, actual);
            speedErrors++;
        end
    endtask

    always begin
        @(checkNow);
        checkCount++;
        checkDir(expName, expDrive.dir, navPkg::navDir_t'(driveDir));
        checkSpeed(expName, expDrive.speed, drivePkg::speed_t'(driveSpeed));
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > RUN_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", RUN_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////
    // test sequence

    initial begin
        toneFlags   = 4'b0000;
        lineSensors = PAT_ZEROS;
        wait (rst === 1'b0);
        @(posedge clk);
        #1;
        requestCheck("reset",
                     expectedDrive(PH_FOLLOW, drivePkg::STEER_NONE, 1'b0, navPkg::STOP));

        // plain line following
        driveLine(PAT_CENTER);
        waitCycles(LINE_WAIT);
        requestCheck("lineCenter",
                     expectedDrive(PH_FOLLOW, drivePkg::STEER_CENTER, 1'b0, navPkg::STOP));
        driveLine(PAT_LEFT);
        waitCycles(LINE_WAIT);
        requestCheck("lineLeft",
                     expectedDrive(PH_FOLLOW, drivePkg::STEER_LEFT, 1'b0, navPkg::STOP));
        driveLine(PAT_RIGHT);
        waitCycles(LINE_WAIT);
        requestCheck("lineRight",
                     expectedDrive(PH_FOLLOW, drivePkg::STEER_RIGHT, 1'b0, navPkg::STOP));
        driveLine(PAT_ZEROS);
        waitCycles(LINE_WAIT);
        requestCheck("lineLost",
                     expectedDrive(PH_FOLLOW, drivePkg::STEER_NONE, 1'b0, navPkg::STOP));
        driveLine(PAT_CENTER);
        waitCycles(LINE_WAIT);

        // glitch too short to latch, junction must wait
        pickBand(band);
        pickGlitch(glitchLen);
        driveTone(4'b0001 << band);
        waitCycles(glitchLen);
        driveTone(4'b0000);
        waitCycles(`NAV_TONE_HOLD + 4);
        driveLine(PAT_ONES);
        waitCycles(LINE_WAIT);
        requestCheck("glitchJunction",
                     expectedDrive(PH_WAIT, drivePkg::STEER_CENTER, 1'b0, navPkg::STOP));
        driveLine(PAT_CENTER);
        waitCycles(LINE_WAIT);
        requestCheck("leaveJunction",
                     expectedDrive(PH_FOLLOW, drivePkg::STEER_CENTER, 1'b0, navPkg::STOP));

        // full tone, slow while qualifying
        pickBand(band);
        driveTone(4'b0001 << band);
        waitCycles(`NAV_TONE_HOLD / 2);
        requestCheck("toneQualifying",
                     expectedDrive(PH_FOLLOW, drivePkg::STEER_CENTER, 1'b1, navPkg::STOP));
        waitCycles(TONE_WAIT);
        requestCheck("toneLatched",
                     expectedDrive(PH_FOLLOW, drivePkg::STEER_CENTER, 1'b0, navPkg::STOP));
        driveTone(4'b0000);

        // turn with the latched band
        driveLine(PAT_ONES);
        waitCycles(LINE_WAIT);
        requestCheck("junctionTurn",
                     expectedDrive(PH_TURN, drivePkg::STEER_CENTER, 1'b0, bandDir(band)));
        driveLine(PAT_CENTER);
        waitCycles(`NAV_TURN_CYCLES + LINE_WAIT);
        requestCheck("afterTurn",
                     expectedDrive(PH_FOLLOW, drivePkg::STEER_CENTER, 1'b0, navPkg::STOP));

        // fresh direction left to expire
        waitCycles(`NAV_DIR_HOLD);
        pickBand(band);
        driveTone(4'b0001 << band);
        waitCycles(TONE_WAIT);
        driveTone(4'b0000);
        waitCycles(`NAV_DIR_HOLD + 10);
        driveLine(PAT_ONES);
        waitCycles(LINE_WAIT);
        requestCheck("holdTimeout",
                     expectedDrive(PH_WAIT, drivePkg::STEER_CENTER, 1'b0, navPkg::STOP));
        driveLine(PAT_CENTER);
        waitCycles(LINE_WAIT);
        requestCheck("leaveExpired",
                     expectedDrive(PH_FOLLOW, drivePkg::STEER_CENTER, 1'b0, navPkg::STOP));

        // stopped at a junction until a tone arrives
        driveLine(PAT_ONES);
        waitCycles(LINE_WAIT);
        requestCheck("noToneJunction",
                     expectedDrive(PH_WAIT, drivePkg::STEER_CENTER, 1'b0, navPkg::STOP));
        pickBand(band);
        driveTone(4'b0001 << band);
        waitCycles(TONE_WAIT);
        requestCheck("toneAtJunction",
                     expectedDrive(PH_TURN, drivePkg::STEER_CENTER, 1'b0, bandDir(band)));
        driveTone(4'b0000);
        driveLine(PAT_CENTER);
        waitCycles(`NAV_TURN_CYCLES + LINE_WAIT);
        requestCheck("resumeFollow",
                     expectedDrive(PH_FOLLOW, drivePkg::STEER_CENTER, 1'b0, navPkg::STOP));

        $display("checks: %0d, direction errors: %0d, speed errors: %0d",
                 checkCount, dirErrors, speedErrors);
        if (dirErrors + speedErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
